/* design/scProc_defs.svh */
`ifndef SCPROC_DEFS_SVH
`define SCPROC_DEFS_SVH

// core data path width
`define SCPROC_XLEN 32

// architectural register count, 4-bit indexes
`define SCPROC_NREGS 16

// instruction memory depth in words
`define SCPROC_IMEM_WORDS 256

// data memory depth in words, indexed by addr[9:2]
`define SCPROC_DMEM_WORDS 256

`endif

/* design/scProcPkg.sv */
`include "scProc_defs.svh"

package scProcPkg;

	typedef enum logic [3:0] {
		opAluR   = 4'b0000, // rd <- rs1 op rs2
		opCmpR   = 4'b0010, // rd <- rs1 cmp rs2
		opSw     = 4'b0101, // mem[rs1 + imm*4] <- rs2
		opBranch = 4'b0110, // pc <- pc+4+imm*4 when compare holds
		opAluI   = 4'b1000, // rd <- rs1 op sext(imm)
		opLw     = 4'b1001, // rd <- mem[rs1 + imm*4]
		opCmpI   = 4'b1010, // rd <- rs1 cmp sext(imm)
		opJal    = 4'b1011  // rd <- pc+4, pc <- rs1 + imm*4
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd  = 4'b0000,
		aluSub  = 4'b0001,
		aluAnd  = 4'b0100,
		aluOr   = 4'b0101,
		aluXor  = 4'b0110,
		aluMvhi = 4'b1011, // imm into upper half
		aluNand = 4'b1100,
		aluNor  = 4'b1101,
		aluXnor = 4'b1110
	} aluFnE;

	typedef enum logic [3:0] {
		cmpF   = 4'b0000, // constant false
		cmpEq  = 4'b0001,
		cmpLt  = 4'b0010,
		cmpLte = 4'b0011,
		cmpT   = 4'b1000, // constant true
		cmpNe  = 4'b1001,
		cmpGte = 4'b1010,
		cmpGt  = 4'b1011
	} cmpFnE;

	typedef struct packed {
		logic [3:0]  dest;  // 31:28
		logic [3:0]  src1;  // 27:24
		logic [3:0]  src2;  // 23:20, upper nibble of imm
		logic [11:0] immLo; // 19:8
		logic [3:0]  fn;    // 7:4
		logic [3:0]  op;    // 3:0
	} rFmtS;

	// store and branch carry no destination
	typedef struct packed {
		logic [3:0]  src1; // 31:28
		logic [3:0]  src2; // 27:24
		logic [15:0] imm;  // 23:8, same bits in both views
		logic [3:0]  fn;
		logic [3:0]  op;
	} sFmtS;

	typedef union packed {
		rFmtS rFmt;
		sFmtS sFmt;
	} iwordU;

	typedef struct packed {
		logic [4:0] aluFn;   // bit 4 picks compare result
		logic regFileWrtEn;
		logic dMemWrtEn;
		logic aluSrc2Sel;    // 1 = extended imm
		logic regFileWrtSel; // 1 = memDOut
		logic isBranch;
		logic isJAL;
		logic needsShift;    // imm << 2 for lw/sw/jal
		logic [3:0] rdIndex0;
		logic [3:0] rdIndex1;
		logic [3:0] wrtIndex;
	} ctrlS;

	typedef struct packed {
		logic valid;
		logic [`SCPROC_XLEN-1:0] pc;
		logic regWrtEn;
		logic [3:0] wrtIndex;
		logic [`SCPROC_XLEN-1:0] wrtData;
		logic memWrtEn;
		logic [`SCPROC_XLEN-1:0] memAddr;
		logic [`SCPROC_XLEN-1:0] memData;
	} retireS;

endpackage

/* design/scProcController.sv */
`timescale 1ns/1ps

module scProcController (
	input scProcPkg::iwordU iword,
	output scProcPkg::ctrlS ctrl
);
	import scProcPkg::*;

	always_comb begin
		ctrl = '0; // every enable low unless decoded
		ctrl.aluFn = {1'b0, iword.rFmt.fn}; // fn passes straight through
		ctrl.rdIndex0 = iword.rFmt.src1;
		ctrl.rdIndex1 = iword.rFmt.src2;
		ctrl.wrtIndex = iword.rFmt.dest;
		case (iword.rFmt.op) // primary opcode
			opAluR: begin
				ctrl.regFileWrtEn = 1'b1; // rs2 operand, aluOut writeback
			end
			opAluI: begin
				ctrl.regFileWrtEn = 1'b1;
				ctrl.aluSrc2Sel = 1'b1; // sext(imm) operand
			end
			opCmpR: begin
				ctrl.aluFn = {1'b1, iword.rFmt.fn}; // compare path
				ctrl.regFileWrtEn = 1'b1;
			end
			opCmpI: begin
				ctrl.aluFn = {1'b1, iword.rFmt.fn};
				ctrl.regFileWrtEn = 1'b1;
				ctrl.aluSrc2Sel = 1'b1;
			end
			opLw: begin
				ctrl.aluFn = {1'b0, aluAdd}; // address = rs1 + imm*4
				ctrl.regFileWrtEn = 1'b1;
				ctrl.aluSrc2Sel = 1'b1;
				ctrl.regFileWrtSel = 1'b1; // load data back
				ctrl.needsShift = 1'b1;
			end
			opSw: begin
				// no destination, sources move up
				ctrl.rdIndex0 = iword.sFmt.src1; // base
				ctrl.rdIndex1 = iword.sFmt.src2; // store data
				ctrl.aluFn = {1'b0, aluAdd};
				ctrl.dMemWrtEn = 1'b1;
				ctrl.aluSrc2Sel = 1'b1;
				ctrl.needsShift = 1'b1;
			end
			opBranch: begin
				ctrl.rdIndex0 = iword.sFmt.src1;
				ctrl.rdIndex1 = iword.sFmt.src2;
				ctrl.aluFn = {1'b1, iword.sFmt.fn}; // reg vs reg compare
				ctrl.isBranch = 1'b1; // taken decision lives in fetch
			end
			opJal: begin
				ctrl.aluFn = {1'b0, aluAdd}; // target = rs1 + imm*4
				ctrl.regFileWrtEn = 1'b1; // link value pc+4
				ctrl.aluSrc2Sel = 1'b1;
				ctrl.isJAL = 1'b1;
				ctrl.needsShift = 1'b1;
			end
			default: ; // undefined op is a no-op, enables stay clear
		endcase
	end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps
`include "scProc_defs.svh"

module regFile (
	input logic clk,
	input logic rstN,
	input logic run,
	input scProcPkg::ctrlS ctrl,
	input logic [`SCPROC_XLEN-1:0] aluOut,
	input logic [`SCPROC_XLEN-1:0] memDOut,
	input logic [`SCPROC_XLEN-1:0] pc,
	output logic [`SCPROC_XLEN-1:0] rdData0,
	output logic [`SCPROC_XLEN-1:0] rdData1
);

	logic [`SCPROC_XLEN-1:0] regs [`SCPROC_NREGS];
	logic [`SCPROC_XLEN-1:0] wrtData;

	always_comb begin
		if (ctrl.isJAL) begin
			wrtData = pc + 32'd4; // link address
		end else if (ctrl.regFileWrtSel) begin
			wrtData = memDOut; // lw
		end else begin
			wrtData = aluOut;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `SCPROC_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (run && ctrl.regFileWrtEn) begin
			regs[ctrl.wrtIndex] <= wrtData; // commit at end of cycle
		end
	end

	assign rdData0 = regs[ctrl.rdIndex0]; // async reads
	assign rdData1 = regs[ctrl.rdIndex1];

endmodule

/* design/arithLogic.sv */
`timescale 1ns/1ps
`include "scProc_defs.svh"

module arithLogic (
	input scProcPkg::aluFnE fn,
	input logic [`SCPROC_XLEN-1:0] a,
	input logic [`SCPROC_XLEN-1:0] b,
	output logic [`SCPROC_XLEN-1:0] y
);
	import scProcPkg::*;

	always_comb begin
		case (fn)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluXor: y = a ^ b;
			aluNand: y = ~(a & b);
			aluNor: y = ~(a | b);
			aluXnor: y = ~(a ^ b);
			aluMvhi: y = {b[15:0], 16'h0000}; // imm to upper half, low half zero
			default: y = '0; // unknown fn
		endcase
	end

endmodule

/* design/compareUnit.sv */
`timescale 1ns/1ps
`include "scProc_defs.svh"

module compareUnit (
	input scProcPkg::cmpFnE fn,
	input logic [`SCPROC_XLEN-1:0] a,
	input logic [`SCPROC_XLEN-1:0] b,
	output logic isTrue
);
	import scProcPkg::*;

	logic isEq;
	logic isLt;

	assign isEq = (a == b);
	assign isLt = ($signed(a) < $signed(b)); // ordered compares are signed

	always_comb begin
		case (fn)
			cmpF: isTrue = 1'b0;
			cmpEq: isTrue = isEq;
			cmpLt: isTrue = isLt;
			cmpLte: isTrue = isLt | isEq;
			cmpT: isTrue = 1'b1;
			cmpNe: isTrue = ~isEq;
			cmpGte: isTrue = ~isLt;
			cmpGt: isTrue = ~(isLt | isEq);
			default: isTrue = 1'b0; // undefined compare reads false
		endcase
	end

endmodule

/* design/execUnit.sv */
`timescale 1ns/1ps
`include "scProc_defs.svh"

module execUnit (
	input scProcPkg::ctrlS ctrl,
	input scProcPkg::iwordU iword,
	input logic [`SCPROC_XLEN-1:0] rdData0,
	input logic [`SCPROC_XLEN-1:0] rdData1,
	output logic [`SCPROC_XLEN-1:0] aluOut,
	output logic cmpTrue
);
	import scProcPkg::*;

	logic [`SCPROC_XLEN-1:0] immExt;
	logic [`SCPROC_XLEN-1:0] immOp;
	logic [`SCPROC_XLEN-1:0] opB;
	logic [`SCPROC_XLEN-1:0] aluY;
	aluFnE aluFn;
	cmpFnE cmpFn;

	// imm occupies 23:8 in either view
	assign immExt = {{(`SCPROC_XLEN-16){iword.sFmt.imm[15]}}, iword.sFmt.imm};
	assign immOp = ctrl.needsShift ? (immExt << 2) : immExt; // word offset for lw/sw/jal
	assign opB = ctrl.aluSrc2Sel ? immOp : rdData1; // branch keeps rs2

	assign aluFn = aluFnE'(ctrl.aluFn[3:0]);
	assign cmpFn = cmpFnE'(ctrl.aluFn[3:0]);

	arithLogic arith_i (
		.fn(aluFn),
		.a (rdData0),
		.b (opB),
		.y (aluY)
	);

	compareUnit cmp_i (
		.fn    (cmpFn),
		.a     (rdData0),
		.b     (opB),
		.isTrue(cmpTrue) // also drives branch decision
	);

	// bit 4 of aluFn picks the compare result, zero extended
	assign aluOut = ctrl.aluFn[4] ? {{(`SCPROC_XLEN-1){1'b0}}, cmpTrue} : aluY;

endmodule

/* design/fetchUnit.sv */
`timescale 1ns/1ps
`include "scProc_defs.svh"

module fetchUnit #(
	parameter int DEPTH = `SCPROC_IMEM_WORDS
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic imemWrtEn,
	input logic [7:0] imemAddr,
	input logic [`SCPROC_XLEN-1:0] imemData,
	input scProcPkg::ctrlS ctrl,
	input logic cmpTrue,
	input logic [`SCPROC_XLEN-1:0] aluOut,
	output scProcPkg::iwordU iword,
	output logic [`SCPROC_XLEN-1:0] pc
);

	localparam int AW = $clog2(DEPTH);

	logic [`SCPROC_XLEN-1:0] imem [DEPTH];
	logic [`SCPROC_XLEN-1:0] pcPlus4;
	logic [`SCPROC_XLEN-1:0] brOffset;
	logic [`SCPROC_XLEN-1:0] nextPc;

	// load port, used while the core is held
	always_ff @(posedge clk) begin
		if (imemWrtEn) begin
			imem[imemAddr[AW-1:0]] <= imemData;
		end
	end

	assign iword = imem[pc[AW+1:2]]; // word index, wraps at DEPTH

	assign pcPlus4 = pc + 32'd4;
	assign brOffset = {{(`SCPROC_XLEN-18){iword.sFmt.imm[15]}}, iword.sFmt.imm, 2'b00}; // imm*4

	always_comb begin
		if (ctrl.isJAL) begin
			nextPc = aluOut; // rs1 + imm*4 from exec
		end else if (ctrl.isBranch && cmpTrue) begin
			nextPc = pcPlus4 + brOffset; // taken branch
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (run) begin
			pc <= nextPc; // frozen while run low
		end
	end

endmodule

/* design/dataMem.sv */
`timescale 1ns/1ps
`include "scProc_defs.svh"

module dataMem #(
	parameter int DEPTH = `SCPROC_DMEM_WORDS
) (
	input logic clk,
	input logic run,
	input scProcPkg::ctrlS ctrl,
	input logic [`SCPROC_XLEN-1:0] addr,
	input logic [`SCPROC_XLEN-1:0] wrData,
	output logic [`SCPROC_XLEN-1:0] memDOut
);

	localparam int AW = $clog2(DEPTH);

	logic [`SCPROC_XLEN-1:0] mem [DEPTH];
	logic [AW-1:0] wordIdx;

	assign wordIdx = addr[AW+1:2]; // byte addr to word, wraps

	always_ff @(posedge clk) begin
		if (run && ctrl.dMemWrtEn) begin
			mem[wordIdx] <= wrData; // sw commit
		end
	end

	assign memDOut = mem[wordIdx]; // async read for lw

endmodule

/* design/scProc.sv */
`timescale 1ns/1ps
`include "scProc_defs.svh"

module scProc (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic imemWrtEn,
	input logic [7:0] imemAddr,
	input logic [`SCPROC_XLEN-1:0] imemData,
	output scProcPkg::retireS retire
);
	import scProcPkg::*;

	iwordU iword;
	ctrlS ctrl;
	logic [`SCPROC_XLEN-1:0] pc;
	logic [`SCPROC_XLEN-1:0] rdData0, rdData1;
	logic [`SCPROC_XLEN-1:0] aluOut;
	logic [`SCPROC_XLEN-1:0] memDOut;
	logic [`SCPROC_XLEN-1:0] wbData;
	logic cmpTrue;

	fetchUnit #(.DEPTH(`SCPROC_IMEM_WORDS)) fetch_i (
		.clk, .rstN, .run, .imemWrtEn, .imemAddr, .imemData,
		.ctrl, .cmpTrue, .aluOut, .iword, .pc
	);

	scProcController ctrlDec_i (.iword, .ctrl);

	regFile regFile_i (
		.clk, .rstN, .run, .ctrl, .aluOut, .memDOut, .pc, .rdData0, .rdData1
	);

	execUnit exec_i (.ctrl, .iword, .rdData0, .rdData1, .aluOut, .cmpTrue);

	dataMem #(.DEPTH(`SCPROC_DMEM_WORDS)) dMem_i (
		.clk, .run, .ctrl,
		.addr   (aluOut),  // rs1 + imm*4
		.wrData (rdData1), // sw source
		.memDOut
	);

	// writeback value as seen by the trace
	assign wbData = ctrl.isJAL ? (pc + 32'd4) : (ctrl.regFileWrtSel ? memDOut : aluOut);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			retire <= '0;
		end else begin
			retire.valid <= run; // one entry per executed cycle
			retire.regWrtEn <= run && ctrl.regFileWrtEn;
			retire.memWrtEn <= run && ctrl.dMemWrtEn;
			if (run) begin
				retire.pc <= pc;
				retire.wrtIndex <= ctrl.wrtIndex;
				retire.wrtData <= wbData;
				retire.memAddr <= aluOut;
				retire.memData <= rdData1;
			end
		end
	end

endmodule

/* dv/scProc_props.sv */
`timescale 1ns/1ps

module scProcProps (
	input logic clk,
	input logic rstN,
	input logic run,
	input scProcPkg::retireS retire
);

	// trace stays empty under reset
	validInReset: assert property (@(posedge clk) !rstN |-> !retire.valid)
		else $error("retire valid high while reset is asserted");

	// no instruction writes both the register file and memory
	oneWriteKind: assert property (@(posedge clk) disable iff (!rstN)
		!(retire.regWrtEn && retire.memWrtEn))
		else $error("retire shows a register write and a memory write together");

	// each valid entry comes from a cycle with run high
	validAfterRun: assert property (@(posedge clk) disable iff (!rstN)
		retire.valid |-> $past(run))
		else $error("retire valid without run in the previous cycle");

endmodule

bind scProc scProcProps props_i (
	.clk,
	.rstN,
	.run,
	.retire
);

/* dv/scProcTb.sv */
`timescale 1ns/1ps
`include "scProc_defs.svh"

module scProcTbClk #(parameter int HALF_NS = 10) (output logic clk);
	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk; // 20 ns period
	end
endmodule

module scProcTb;
	import scProcPkg::*;

	localparam int RST_CYC = 16;
	localparam int RUN_LEN = 200;
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYC = `SCPROC_IMEM_WORDS + RST_CYC + RUN_LEN + 16; // load, reset, run, slack
	localparam int WATCHDOG_NS = (NUM_TESTS * TEST_CYC + RST_CYC) * 20 * 2;
	localparam int K_ALU = 0;
	localparam int K_CMP = 1;
	localparam int K_MEM = 2;
	localparam int K_FLOW = 3;
	localparam int K_UNDEF = 4;

	logic clk;
	logic rstN;
	logic run;
	logic imemWrtEn;
	logic [7:0] imemAddr;
	logic [`SCPROC_XLEN-1:0] imemData;
	retireS retire;
	integer seed;
	int testErrs;
	int failedTests;
	logic [31:0] prog [`SCPROC_IMEM_WORDS]; // program image, patched by the model
	logic [31:0] mRegs [`SCPROC_NREGS];
	logic [31:0] mMem [`SCPROC_DMEM_WORDS]; // survives resets like the DUT memory
	bit mKnown [`SCPROC_DMEM_WORDS];
	logic [7:0] writtenQ [$];
	logic [31:0] mPc;
	retireS expQ [$]; // predicted trace, in order

	scProcTbClk clkGen_i (.clk);

	scProc scProc_i (.clk, .rstN, .run, .imemWrtEn, .imemAddr, .imemData, .retire);

	function automatic logic [31:0] rnd32();
		return $random(seed);
	endfunction

	function automatic logic [31:0] aluModel(input logic [3:0] fn, input logic [31:0] a,
			input logic [31:0] b);
		case (fn)
			4'h0: return a + b;
			4'h1: return a - b;
			4'h4: return a & b;
			4'h5: return a | b;
			4'h6: return a ^ b;
			4'hb: return {b[15:0], 16'h0000}; // mvhi
			4'hc: return ~(a & b);
			4'hd: return ~(a | b);
			4'he: return ~(a ^ b);
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic cmpModel(input logic [3:0] fn, input logic [31:0] a,
			input logic [31:0] b);
		case (fn)
			4'h1: return a == b;
			4'h2: return $signed(a) < $signed(b);
			4'h3: return $signed(a) <= $signed(b);
			4'h8: return 1'b1;
			4'h9: return a != b;
			4'ha: return $signed(a) >= $signed(b);
			4'hb: return $signed(a) > $signed(b);
			default: return 1'b0; // f
		endcase
	endfunction

	function automatic logic [31:0] genWord(input int kind);
		logic [31:0] r;
		logic [31:0] s;
		logic [3:0] op;
		logic [3:0] fn;
		r = rnd32(); // fields
		s = rnd32(); // choices
		op = s[8] ? 4'b1000 : 4'b0000;
		fn = r[7:4]; // all 16 alu codes
		if (kind == K_CMP || (kind == K_FLOW && s[3:0] > 4'h4 && s[3:0] < 4'h9)) begin
			op = s[8] ? 4'b1010 : 4'b0010;
			fn = {s[2], 1'b0, s[1:0]}; // the eight defined compares
		end else if (kind == K_MEM) begin
			op = s[1] ? (s[0] ? 4'b1000 : 4'b1001) : 4'b0101; // half stores
			fn = s[1] && s[0] ? 4'h0 : fn; // alu-i add moves bases around
		end else if (kind == K_FLOW && s[3:0] == 4'h0) begin
			op = 4'b1011; // jal, rare
		end else if (kind == K_FLOW && s[3:0] < 4'h5) begin
			op = 4'b0110;
			fn = {s[6], 1'b0, s[5:4]};
		end else if (kind == K_UNDEF && !s[8]) begin
			op = {s[3], s[3] | s[2], s[3] ? s[1] : (s[2] ? s[1] : 1'b1), 1'b1 ^ (s[2] & ~s[3])};
			op = (op == 4'b0101 || op == 4'b0110) ? 4'b1111 : op;
		end
		return {r[31:8], fn, op};
	endfunction

	task automatic stepModel(input bit fixLoads);
		logic [31:0] iw;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] nextPc;
		logic [7:0] want;
		retireS e;
		iw = prog[mPc[9:2]];
		e = '0;
		e.valid = 1'b1;
		e.pc = mPc;
		imm = {{16{iw[23]}}, iw[23:8]};
		a = mRegs[iw[27:24]]; // source one of the r view
		b = iw[3] ? imm : mRegs[iw[23:20]];
		nextPc = mPc + 32'd4;
		e.wrtIndex = iw[31:28];
		case (iw[3:0])
			4'b0000, 4'b1000: e.wrtData = aluModel(iw[7:4], a, b);
			4'b0010, 4'b1010: e.wrtData = {31'b0, cmpModel(iw[7:4], a, b)};
			4'b1001: begin
				addr = a + (imm << 2);
				if (fixLoads && !mKnown[addr[9:2]]) begin
					want = writtenQ[rnd32() % writtenQ.size()]; // aim at a stored word
					iw[15:8] = want - a[9:2];
					prog[mPc[9:2]] = iw;
					imm = {{16{iw[23]}}, iw[23:8]};
					addr = a + (imm << 2);
				end
				e.wrtData = mMem[addr[9:2]];
			end
			4'b0101: begin
				e.memAddr = mRegs[iw[31:28]] + (imm << 2); // base in the s view
				e.memData = mRegs[iw[27:24]];
				mMem[e.memAddr[9:2]] = e.memData;
				mKnown[e.memAddr[9:2]] = 1'b1;
				writtenQ.push_back(e.memAddr[9:2]);
			end
			4'b0110: begin
				if (cmpModel(iw[7:4], mRegs[iw[31:28]], mRegs[iw[27:24]])) begin
					nextPc = mPc + 32'd4 + (imm << 2);
				end
			end
			4'b1011: begin
				e.wrtData = mPc + 32'd4; // link
				nextPc = a + (imm << 2);
			end
			default: ;
		endcase
		e.regWrtEn = iw[3:0] inside {4'b0000, 4'b1000, 4'b0010, 4'b1010, 4'b1001, 4'b1011};
		e.memWrtEn = (iw[3:0] == 4'b0101);
		if (e.regWrtEn) begin
			mRegs[e.wrtIndex] = e.wrtData;
		end
		mPc = nextPc;
		expQ.push_back(e);
	endtask

	task automatic tick();
		@(posedge clk);
		#2; // drive point, retire settled
	endtask

	task automatic checkField(input string name, input logic [31:0] act, input logic [31:0] exp);
		assert (act === exp) else begin
			$display("[ERROR] %0d ns %s expected %h got %h", $time, name, exp, act);
			testErrs++;
		end
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		repeat (RST_CYC) tick();
		rstN = 1'b1;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < `SCPROC_IMEM_WORDS; i++) begin
			imemWrtEn = 1'b1;
			imemAddr = 8'(i);
			imemData = prog[i];
			tick();
		end
		imemWrtEn = 1'b0;
	endtask

	task automatic runProgram(input int n);
		int issued;
		int seen;
		int idle;
		retireS e;
		issued = 0;
		seen = 0;
		idle = 0;
		run = 1'b1;
		while (seen < n && idle < 4) begin
			@(posedge clk);
			issued += run ? 1 : 0; // an instruction executes on this edge
			#2;
			idle = retire.valid ? 0 : idle + 1;
			if (retire.valid) begin
				e = expQ.pop_front();
				seen++;
				checkField("retire.pc", retire.pc, e.pc);
				checkField("retire.regWrtEn", 32'(retire.regWrtEn), 32'(e.regWrtEn));
				checkField("retire.memWrtEn", 32'(retire.memWrtEn), 32'(e.memWrtEn));
				if (e.regWrtEn) begin
					checkField("retire.wrtIndex", 32'(retire.wrtIndex), 32'(e.wrtIndex));
					checkField("retire.wrtData", retire.wrtData, e.wrtData);
				end
				if (e.memWrtEn) begin
					checkField("retire.memAddr", retire.memAddr, e.memAddr);
					checkField("retire.memData", retire.memData, e.memData);
				end
			end
			run = (issued < n);
		end
		run = 1'b0; // core held again
		assert (seen == n) else begin
			$display("retire trace stopped after %0d of %0d instructions", seen, n);
			testErrs++;
		end
		tick();
		checkField("retire.valid", 32'(retire.valid), 32'd0); // dropped after run low
	endtask

	task automatic doTest(input string name, input int kind, input int n, input bit idleFirst);
		testErrs = 0;
		for (int i = 0; i < `SCPROC_IMEM_WORDS; i++) begin
			prog[i] = genWord(kind);
		end
		if (kind == K_MEM) begin
			prog[0] = {prog[0][31:8], 4'h0, 4'b0101}; // store first so loads find data
		end
		for (int i = 0; i < `SCPROC_NREGS; i++) begin
			mRegs[i] = '0;
		end
		mPc = '0;
		expQ.delete();
		repeat (n) stepModel(kind == K_MEM);
		loadProgram();
		applyReset();
		if (idleFirst) begin
			repeat (8) begin
				tick();
				checkField("retire.valid", 32'(retire.valid), 32'd0); // held core
			end
		end
		runProgram(n);
		failedTests += (testErrs != 0) ? 1 : 0;
		$display("test %-10s %s, %0d instructions, %0d errors", name,
			(testErrs == 0) ? "pass" : "fail", n, testErrs);
	endtask

	initial begin
		seed = 72457;
		rstN = 1'b0;
		run = 1'b0;
		imemWrtEn = 1'b0;
		imemAddr = '0;
		imemData = '0;
		failedTests = 0;
		applyReset();
		doTest("reset", K_ALU, 16, 1'b1);
		doTest("alu", K_ALU, RUN_LEN, 1'b0);
		doTest("compare", K_CMP, RUN_LEN, 1'b0);
		doTest("loadStore", K_MEM, RUN_LEN, 1'b0);
		doTest("flow", K_FLOW, RUN_LEN, 1'b0);
		doTest("undefOp", K_UNDEF, RUN_LEN, 1'b0);
		$display("tests %0d, passed %0d, failed %0d", NUM_TESTS, NUM_TESTS - failedTests,
			failedTests);
		if (failedTests == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#WATCHDOG_NS; // bound from the test lengths
		$display("timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* scProc.f */
+incdir+design
design/scProcPkg.sv
design/scProcController.sv
design/regFile.sv
design/arithLogic.sv
design/compareUnit.sv
design/execUnit.sv
design/fetchUnit.sv
design/dataMem.sv
design/scProc.sv
dv/scProc_props.sv
dv/scProcTb.sv

/* run.sh */
#!/bin/sh
# build and run the scProc testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module scProcTb -f scProc.f -o scProcSim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/scProcSim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1
